// File: arb_macros.svh
// Requester count, scheme width, AXI4-Lite widths and register offsets
`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

// Requesters sharing the resource
`define ARB_NUM_REQ 4

// Width of the scheme field in the SCHEME register
`define ARB_SCHEME_W 3

// AXI4-Lite bus widths
`define AXIL_ADDR_W 8
`define AXIL_DATA_W 32

// Register map, byte offsets
`define ARB_REG_SCHEME 8'h00
`define ARB_REG_CNT0   8'h04
`define ARB_REG_CNT1   8'h08
`define ARB_REG_CNT2   8'h0C
`define ARB_REG_CNT3   8'h10
`define ARB_REG_STATUS 8'h14

`endif

// File: arb_pkg.sv
// Arbitration scheme encoding and request/grant vector types
`include "arb_macros.svh"

package arb_pkg;

  // Codes 6 and 7 are illegal and yield no grant
  typedef enum logic [`ARB_SCHEME_W-1:0] {
    SCHEME_PRIO0 = 3'd0,
    SCHEME_PRIO1 = 3'd1,
    SCHEME_PRIO2 = 3'd2,
    SCHEME_PRIO3 = 3'd3,
    SCHEME_RR    = 3'd4,
    SCHEME_RAND  = 3'd5
  } arb_scheme_e;

  // One bit per requester
  typedef logic [`ARB_NUM_REQ-1:0] req_vec_t;

  // Registered grant, one-hot or zero
  typedef logic [`ARB_NUM_REQ-1:0] gnt_vec_t;

endpackage

// File: axil_pkg.sv
// AXI4-Lite request and response structs and response codes
`include "arb_macros.svh"

package axil_pkg;

  // Response codes
  localparam logic [1:0] AXIL_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXIL_RESP_SLVERR = 2'b10;

  // Master to slave
  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0]   awaddr;
    logic                      awvalid;
    logic [`AXIL_DATA_W-1:0]   wdata;
    logic [`AXIL_DATA_W/8-1:0] wstrb;
    logic                      wvalid;
    logic                      bready;
    logic [`AXIL_ADDR_W-1:0]   araddr;
    logic                      arvalid;
    logic                      rready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic                    awready;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    arready;
    logic [`AXIL_DATA_W-1:0] rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
  } axil_rsp_t;

endpackage

// File: pn_seq_gen.sv
// Three-stage LFSR producing a two-bit pseudo-random selector
`timescale 1ns/1ns

module pn_seq_gen (
  input  logic       clk,
  input  logic       rst_n,
  output logic [1:0] rand_sel
);

  logic s1;
  logic s2;
  logic s3;
  logic fb;

  // Taps on stages one and three, period 7
  assign fb = s1 ^ s3;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= 1'b1;
      s2 <= 1'b0;
      s3 <= 1'b0;
    end else begin
      s1 <= fb;
      s2 <= s1;
      s3 <= s2;
    end
  end

  // Selects the promoted requester for the random scheme
  assign rand_sel = {s3, s2};

endmodule

// File: grant_arbiter.sv
// Registered four-way arbiter with fixed-priority, round-robin and random schemes
`timescale 1ns/1ns
`include "arb_macros.svh"

module grant_arbiter
  import arb_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  req_vec_t    req,
  input  arb_scheme_e scheme,
  output gnt_vec_t    gnt
);

  logic [1:0] rand_sel;
  logic [1:0] last_idx;
  gnt_vec_t   gnt_fixed;
  gnt_vec_t   gnt_rr;
  gnt_vec_t   gnt_rand;
  gnt_vec_t   gnt_next;
  gnt_vec_t   gnt_q;

  // Requester k first, otherwise the lowest-numbered requester
  function automatic gnt_vec_t fixed_grant(input req_vec_t r, input logic [1:0] k);
    gnt_vec_t g;
    g = '0;
    if (r[k]) begin
      g[k] = 1'b1;
    end else begin
      // Walk downwards so the lowest set bit is the one that remains
      for (int i = `ARB_NUM_REQ - 1; i >= 0; i--) begin
        if (r[i]) begin
          g    = '0;
          g[i] = 1'b1;
        end
      end
    end
    return g;
  endfunction

  // Cyclic search starting one past the last granted requester
  function automatic gnt_vec_t rr_grant(input req_vec_t r, input logic [1:0] last);
    gnt_vec_t   g;
    logic [1:0] idx;
    g = '0;
    // Farthest candidate first, nearest one overrides
    for (int i = `ARB_NUM_REQ; i >= 1; i--) begin
      idx = last + 2'(i);
      if (r[idx]) begin
        g      = '0;
        g[idx] = 1'b1;
      end
    end
    return g;
  endfunction

  pn_seq_gen u_pn_seq_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_sel (rand_sel)
  );

  // Index of the current grant, zero when idle
  assign last_idx = {gnt_q[3] | gnt_q[2], gnt_q[3] | gnt_q[1]};

  // Low two scheme bits name the promoted requester for PRIO0..PRIO3
  assign gnt_fixed = fixed_grant(req, scheme[1:0]);
  assign gnt_rr    = rr_grant(req, last_idx);
  assign gnt_rand  = fixed_grant(req, rand_sel);

  always_comb begin
    case (scheme)
      SCHEME_PRIO0,
      SCHEME_PRIO1,
      SCHEME_PRIO2,
      SCHEME_PRIO3: gnt_next = gnt_fixed;
      SCHEME_RR:    gnt_next = gnt_rr;
      SCHEME_RAND:  gnt_next = gnt_rand;
      // Codes 6 and 7
      default:      gnt_next = '0;
    endcase
  end

  // One cycle from request to grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_q <= '0;
    end else begin
      gnt_q <= gnt_next;
    end
  end

  assign gnt = gnt_q;

endmodule

// File: arb_csr_axil.sv
// AXI4-Lite slave with scheme register, per-requester grant counters and status
`timescale 1ns/1ns
`include "arb_macros.svh"

module arb_csr_axil
  import arb_pkg::*;
  import axil_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  axil_req_t   axil_req,
  output axil_rsp_t   axil_rsp,
  input  gnt_vec_t    gnt,
  output arb_scheme_e scheme
);

  logic                    wr_en;
  logic                    rd_en;
  logic                    wr_hit;
  logic                    rd_hit;
  logic                    scheme_we;
  logic [`ARB_NUM_REQ-1:0] cnt_clr;
  logic [`AXIL_DATA_W-1:0] rd_data;

  arb_scheme_e             scheme_q;
  logic [`AXIL_DATA_W-1:0] cnt_q [`ARB_NUM_REQ];
  logic                    bvalid_q;
  logic                    rvalid_q;
  logic [1:0]              bresp_q;
  logic [1:0]              rresp_q;
  logic [`AXIL_DATA_W-1:0] rdata_q;

  // Address and data accepted together, one response outstanding per channel
  assign wr_en = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
  assign rd_en = axil_req.arvalid & ~rvalid_q;

  // Write decode, wstrb ignored
  always_comb begin
    wr_hit    = 1'b1;
    scheme_we = 1'b0;
    cnt_clr   = '0;
    case (axil_req.awaddr)
      `ARB_REG_SCHEME: scheme_we  = wr_en;
      `ARB_REG_CNT0:   cnt_clr[0] = wr_en;
      `ARB_REG_CNT1:   cnt_clr[1] = wr_en;
      `ARB_REG_CNT2:   cnt_clr[2] = wr_en;
      `ARB_REG_CNT3:   cnt_clr[3] = wr_en;
      // Read-only, write accepted and dropped
      `ARB_REG_STATUS: wr_hit     = 1'b1;
      default:         wr_hit     = 1'b0;
    endcase
  end

  // Read mux, unknown offsets return zero
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (axil_req.araddr)
      `ARB_REG_SCHEME: rd_data[`ARB_SCHEME_W-1:0] = scheme_q;
      `ARB_REG_CNT0:   rd_data = cnt_q[0];
      `ARB_REG_CNT1:   rd_data = cnt_q[1];
      `ARB_REG_CNT2:   rd_data = cnt_q[2];
      `ARB_REG_CNT3:   rd_data = cnt_q[3];
      `ARB_REG_STATUS: rd_data[`ARB_NUM_REQ-1:0] = gnt;
      default:         rd_hit = 1'b0;
    endcase
  end

  // Only the low scheme bits are kept
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scheme_q <= SCHEME_PRIO0;
    end else if (scheme_we) begin
      scheme_q <= arb_scheme_e'(axil_req.wdata[`ARB_SCHEME_W-1:0]);
    end
  end

  // Wrapping grant counters, a clearing write wins over an increment
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `ARB_NUM_REQ; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `ARB_NUM_REQ; i++) begin
        if (cnt_clr[i]) begin
          cnt_q[i] <= '0;
        end else if (gnt[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // Response valids hold until the master takes them
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_en) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_en) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      bresp_q <= wr_hit ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
    end
    if (rd_en) begin
      rdata_q <= rd_data;
      rresp_q <= rd_hit ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
    end
  end

  assign axil_rsp.awready = wr_en;
  assign axil_rsp.wready  = wr_en;
  assign axil_rsp.bresp   = bresp_q;
  assign axil_rsp.bvalid  = bvalid_q;
  assign axil_rsp.arready = rd_en;
  assign axil_rsp.rdata   = rdata_q;
  assign axil_rsp.rresp   = rresp_q;
  assign axil_rsp.rvalid  = rvalid_q;

  assign scheme = scheme_q;

endmodule

// File: arb_top.sv
// Arbitration block top level with register interface and grant arbiter
`timescale 1ns/1ns

module arb_top
  import arb_pkg::*;
  import axil_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  input  req_vec_t  req,
  output gnt_vec_t  gnt
);

  arb_scheme_e scheme;
  gnt_vec_t    gnt_int;

  // Register block, counts grants and reports them in STATUS
  arb_csr_axil u_csr (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .gnt      (gnt_int),
    .scheme   (scheme)
  );

  // Grant is registered inside the arbiter
  grant_arbiter u_arbiter (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .scheme (scheme),
    .gnt    (gnt_int)
  );

  assign gnt = gnt_int;

endmodule

// File: arb_chk.sv
// Concurrent assertions on the registered grant, bound into grant_arbiter
`timescale 1ns/1ns

module arb_chk
  import arb_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input req_vec_t    req,
  input arb_scheme_e scheme,
  input gnt_vec_t    gnt
);

  // Failures seen so far, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // At most one requester holds the resource
  gnt_onehot0_a: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
    else begin
      $error("gnt 0x%0h is neither zero nor one-hot", gnt);
      fail_cnt++;
    end

  // A grant only goes to a requester that asked in the cycle before
  gnt_has_req_a: assert property (@(posedge clk) disable iff (!rst_n)
    (gnt & ~$past(req)) == '0)
    else begin
      $error("gnt 0x%0h without matching req 0x%0h", gnt, $past(req));
      fail_cnt++;
    end

  // Codes 6 and 7 give no grant
  illegal_scheme_a: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(scheme) == 3'd6 || $past(scheme) == 3'd7) |-> gnt == '0)
    else begin
      $error("gnt 0x%0h under illegal scheme", gnt);
      fail_cnt++;
    end

  // Requester 0 first, then ascending, no lower requester passed over
  prio0_order_a: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(scheme) == SCHEME_PRIO0 && gnt != '0) |-> (((gnt - 1'b1) & $past(req)) == '0))
    else begin
      $error("gnt 0x%0h skips a lower req in 0x%0h", gnt, $past(req));
      fail_cnt++;
    end

endmodule

bind grant_arbiter arb_chk arb_chk_i (
  .clk    (clk),
  .rst_n  (rst_n),
  .req    (req),
  .scheme (scheme),
  .gnt    (gnt)
);

// File: tb_arb_top.sv
// Testbench for arb_top with random requests, AXI4-Lite register access and a grant model
`timescale 1ns/1ns
`include "arb_macros.svh"

module tb_arb_top
  import arb_pkg::*;
  import axil_pkg::*;
();

  localparam int CLK_PERIOD      = 8;
  localparam int NUM_ACCESSES    = 40;
  localparam int ACCESS_CYCLES   = 12;
  localparam int WATCHDOG_CYCLES = 16 + 4 * 200 + 300 + 300 + 2 * 50 + 30
                                   + NUM_ACCESSES * ACCESS_CYCLES + 500;

  logic      clk;
  logic      rst_n;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  req_vec_t  req;
  gnt_vec_t  gnt;

  // Reference model state
  logic [2:0]  m_scheme;
  logic        m_s1;
  logic        m_s2;
  logic        m_s3;
  gnt_vec_t    m_gnt;
  logic [31:0] m_cnt [`ARB_NUM_REQ];
  int unsigned errors;
  logic [1:0]  resp;

  arb_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .req      (req),
    .gnt      (gnt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("Error: %s expected 0x%08h, got 0x%08h at %0t ns", name, exp, act, $time);
    end
  endtask

  // Promoted requester k, else the first requester counting up from 0
  function automatic gnt_vec_t priority_pick(input req_vec_t r, input logic [1:0] k);
    gnt_vec_t g;
    g = '0;
    if (r[k]) begin
      g[k] = 1'b1;
    end else begin
      for (int i = 0; i < `ARB_NUM_REQ; i++) begin
        if (r[i] && g == '0) begin
          g[i] = 1'b1;
        end
      end
    end
    return g;
  endfunction

  // Search starts one after the previous winner, or at 1 when idle
  function automatic gnt_vec_t rotate_pick(input req_vec_t r, input gnt_vec_t prev);
    gnt_vec_t g;
    int       start;
    int       j;
    g     = '0;
    start = 1;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (prev[i]) begin
        start = i + 1;
      end
    end
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      j = (start + i) % `ARB_NUM_REQ;
      if (r[j] && g == '0) begin
        g[j] = 1'b1;
      end
    end
    return g;
  endfunction

  function automatic gnt_vec_t expected_grant(input req_vec_t r, input logic [2:0] s,
                                              input logic [1:0] rsel, input gnt_vec_t prev);
    case (s)
      3'd0, 3'd1, 3'd2, 3'd3: return priority_pick(r, s[1:0]);
      3'd4:                   return rotate_pick(r, prev);
      3'd5:                   return priority_pick(r, rsel);
      default:                return '0;
    endcase
  endfunction

  // Model steps once per clock, between edges where all signals are settled
  always @(negedge clk) begin : model_step
    gnt_vec_t nxt;
    logic     wr_acc;
    if (rst_n) begin
      check_value("gnt", m_gnt, gnt);
      wr_acc = axil_req.awvalid & axil_req.wvalid & axil_rsp.awready & axil_rsp.wready;
      nxt    = expected_grant(req, m_scheme, {m_s3, m_s2}, m_gnt);
      for (int i = 0; i < `ARB_NUM_REQ; i++) begin
        if (wr_acc && axil_req.awaddr == `ARB_REG_CNT0 + 8'(4 * i)) begin
          m_cnt[i] = '0;
        end else if (m_gnt[i]) begin
          m_cnt[i] = m_cnt[i] + 1;
        end
      end
      // New scheme applies from the following edge on
      if (wr_acc && axil_req.awaddr == `ARB_REG_SCHEME) begin
        m_scheme = axil_req.wdata[2:0];
      end
      {m_s1, m_s2, m_s3} = {m_s1 ^ m_s3, m_s1, m_s2};
      m_gnt = nxt;
    end
  end

  // Mode 0 idle, 1 random, 2 all requesting
  task automatic run_cycles(input int mode, input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      case (mode)
        1:       req = req_vec_t'($urandom);
        2:       req = '1;
        default: req = '0;
      endcase
    end
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] bresp);
    int unsigned hold;
    @(posedge clk);
    #1;
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = '1;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    @(negedge clk);
    while (!axil_rsp.awready) @(negedge clk);
    @(posedge clk);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    hold = $urandom_range(3, 0);
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    axil_req.bready = 1'b1;
    @(negedge clk);
    while (!axil_rsp.bvalid) @(negedge clk);
    bresp = axil_rsp.bresp;
    @(posedge clk);
    #1;
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] rdata,
                           output logic [1:0] rresp);
    int unsigned hold;
    @(posedge clk);
    #1;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    @(negedge clk);
    while (!axil_rsp.arready) @(negedge clk);
    @(posedge clk);
    #1;
    axil_req.arvalid = 1'b0;
    hold = $urandom_range(3, 0);
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    axil_req.rready = 1'b1;
    @(negedge clk);
    while (!axil_rsp.rvalid) @(negedge clk);
    rdata = axil_rsp.rdata;
    rresp = axil_rsp.rresp;
    @(posedge clk);
    #1;
    axil_req.rready = 1'b0;
  endtask

  task automatic check_read(input logic [7:0] addr, input logic [31:0] exp,
                            input logic [1:0] exp_resp, input string name);
    logic [31:0] data;
    logic [1:0]  rresp;
    axil_read(addr, data, rresp);
    check_value(name, exp, data);
    check_value("rresp", exp_resp, rresp);
  endtask

  task automatic write_scheme(input logic [31:0] code);
    logic [1:0] bresp;
    axil_write(`ARB_REG_SCHEME, code, bresp);
    check_value("bresp", AXIL_RESP_OKAY, bresp);
    check_read(`ARB_REG_SCHEME, code, AXIL_RESP_OKAY, "SCHEME");
  endtask

  // From idle with all four requesting, grants step 1, 2, 3, 0 and onwards
  task automatic check_rotation();
    gnt_vec_t exp;
    @(posedge clk);
    #1;
    req = '1;
    @(negedge clk);
    while (gnt == '0) @(negedge clk);
    exp = 4'b0010;
    check_value("gnt", exp, gnt);
    repeat (8) begin
      @(negedge clk);
      exp = {exp[2:0], exp[3]};
      check_value("gnt", exp, gnt);
    end
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    axil_req = '0;
    req      = '0;
    m_scheme = 3'd0;
    m_s1     = 1'b1;
    m_s2     = 1'b0;
    m_s3     = 1'b0;
    m_gnt    = '0;
    errors   = 0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      m_cnt[i] = '0;
    end
    void'($urandom(32'hbec4fae7));
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset values
    run_cycles(0, 2);
    check_read(`ARB_REG_SCHEME, 0, AXIL_RESP_OKAY, "SCHEME");
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      check_read(`ARB_REG_CNT0 + 8'(4 * i), 0, AXIL_RESP_OKAY, $sformatf("CNT%0d", i));
    end
    check_read(`ARB_REG_STATUS, 0, AXIL_RESP_OKAY, "STATUS");

    for (int k = 0; k < 4; k++) begin
      write_scheme(k);
      run_cycles(1, 200);
    end

    write_scheme(SCHEME_RR);
    run_cycles(1, 300);
    run_cycles(0, 2);
    check_rotation();

    write_scheme(SCHEME_RAND);
    run_cycles(1, 300);

    // Illegal codes
    for (int s = 6; s < 8; s++) begin
      write_scheme(s);
      run_cycles(1, 50);
    end

    // Counters, clearing writes and an unmapped offset
    run_cycles(0, 2);
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      check_read(`ARB_REG_CNT0 + 8'(4 * i), m_cnt[i], AXIL_RESP_OKAY, $sformatf("CNT%0d", i));
      axil_write(`ARB_REG_CNT0 + 8'(4 * i), $urandom, resp);
      check_value("bresp", AXIL_RESP_OKAY, resp);
      check_read(`ARB_REG_CNT0 + 8'(4 * i), 0, AXIL_RESP_OKAY, $sformatf("CNT%0d", i));
    end
    axil_write(`ARB_REG_STATUS, 32'hf, resp);
    check_value("bresp", AXIL_RESP_OKAY, resp);
    check_read(8'h18, 0, AXIL_RESP_SLVERR, "rdata");

    $display("Errors: %0d value mismatches, %0d assertion failures",
             errors, dut_i.u_arbiter.arb_chk_i.fail_cnt);
    if (errors == 0 && dut_i.u_arbiter.arb_chk_i.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Bounded run time
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: project.f
+incdir+.
arb_pkg.sv
axil_pkg.sv
pn_seq_gen.sv
grant_arbiter.sv
arb_csr_axil.sv
arb_top.sv
arb_chk.sv
tb_arb_top.sv

// File: Bender.yml
package:
  name: arb_top

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - arb_pkg.sv
      - axil_pkg.sv
      - pn_seq_gen.sv
      - grant_arbiter.sv
      - arb_csr_axil.sv
      - arb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - arb_chk.sv
      - tb_arb_top.sv
